// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module pcie_config_tb
	out="$$(./obj_dir/Vpcie_config_tb)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: files.f
hw/pcie_config_pkg.sv
hw/axil_reg_if.sv
hw/gpio_i2c_regs.sv
hw/bpi_flash_regs.sv
hw/host_dma_channel.sv
hw/host_dma_regs.sv
hw/pcie_config_top.sv
test/pcie_config_checker.sv
test/pcie_config_tb.sv

// File: hw/axil_reg_if.sv
module axil_reg_if
  import pcie_config_pkg::*;
(
  input  logic                   pcie_clk,
  input  logic                   pcie_rst,

  input  logic [31:0]            awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic [AXIL_DATA_W-1:0] wdata_i,
  input  logic [AXIL_STRB_W-1:0] wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output logic [1:0]             bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  input  logic [31:0]            araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [AXIL_DATA_W-1:0] rdata_o,
  output logic [1:0]             rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,

  output reg_wr_t                reg_wr_o,
  output reg_rd_t                reg_rd_o,
  input  logic [AXIL_DATA_W-1:0] gpio_rd_data_i,
  input  logic [AXIL_DATA_W-1:0] flash_rd_data_i,
  input  logic [AXIL_DATA_W-1:0] dma_rd_data_i
);

  logic                   wr_accept;
  logic                   rd_accept;
  logic [AXIL_DATA_W-1:0] id_data;

  // Only one outstanding response per direction
  assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
  assign rd_accept = arvalid_i && !rvalid_o;

  assign reg_wr_o = '{valid: wr_accept,
                      addr:  {awaddr_i[REG_ADDR_W-1:2], 2'b00},
                      data:  wdata_i,
                      strb:  wstrb_i};
  assign reg_rd_o = '{valid: rd_accept,
                      addr:  {araddr_i[REG_ADDR_W-1:2], 2'b00}};

  assign bresp_o = 2'b00;
  assign rresp_o = 2'b00;

  always_comb begin
    case (reg_rd_o.addr)
      REG_FW_ID:          id_data = FW_ID;
      REG_FW_VER:         id_data = FW_VER;
      REG_BOARD_ID:       id_data = BOARD_ID;
      REG_BOARD_VER:      id_data = BOARD_VER;
      REG_PHC_COUNT:      id_data = '0; // No PHC instances
      REG_PHC_OFFSET:     id_data = PHC_OFFSET;
      REG_PHC_STRIDE:     id_data = PHC_STRIDE;
      REG_IF_COUNT:       id_data = IF_COUNT;
      REG_IF_STRIDE:      id_data = IF_STRIDE;
      REG_IF_CTRL_OFFSET: id_data = IF_CTRL_OFFSET;
      default:            id_data = '0;
    endcase
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      awready_o <= wr_accept; // One cycle, bvalid blocks the next accept
      wready_o  <= wr_accept;
      bvalid_o  <= wr_accept || (bvalid_o && !bready_i);
      arready_o <= rd_accept;
      rvalid_o  <= rd_accept || (rvalid_o && !rready_i);
    end
  end

  // Blocks return zero for addresses they do not own
  always_ff @(posedge pcie_clk) begin
    if (rd_accept) begin
      rdata_o <= id_data | gpio_rd_data_i | flash_rd_data_i | dma_rd_data_i;
    end
  end

endmodule

// File: hw/bpi_flash_regs.sv
module bpi_flash_regs
  import pcie_config_pkg::*;
(
  input  logic                   pcie_clk,
  input  logic                   pcie_rst,
  input  reg_wr_t                reg_wr_i,
  input  reg_rd_t                reg_rd_i,
  input  logic [FLASH_DQ_W-1:0]  flash_dq_i,
  output flash_out_t             flash_o,
  output logic [AXIL_DATA_W-1:0] rd_data_o
);

  logic wr_addr;
  logic wr_data;
  logic wr_ctrl;

  assign wr_addr = reg_wr_i.valid && reg_wr_i.addr == REG_FLASH_ADDR;
  assign wr_data = reg_wr_i.valid && reg_wr_i.addr == REG_FLASH_DATA;
  assign wr_ctrl = reg_wr_i.valid && reg_wr_i.addr == REG_FLASH_CTRL;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      flash_o       <= '0;
      flash_o.ce_n  <= 1'b1;
      flash_o.oe_n  <= 1'b1;
      flash_o.we_n  <= 1'b1;
      flash_o.adv_n <= 1'b1;
    end else begin
      if (wr_addr) begin
        if (reg_wr_i.strb[0]) flash_o.addr[7:0] <= reg_wr_i.data[7:0];
        if (reg_wr_i.strb[1]) flash_o.addr[15:8] <= reg_wr_i.data[15:8];
        if (reg_wr_i.strb[2]) begin
          flash_o.addr[22:16] <= reg_wr_i.data[22:16];
          flash_o.region      <= reg_wr_i.data[23]; // Address bit 23
        end
      end
      if (wr_data) begin
        if (reg_wr_i.strb[0]) flash_o.dq[7:0] <= reg_wr_i.data[7:0];
        if (reg_wr_i.strb[1]) flash_o.dq[15:8] <= reg_wr_i.data[15:8];
      end
      if (wr_ctrl) begin
        if (reg_wr_i.strb[0]) begin
          flash_o.ce_n  <= reg_wr_i.data[0];
          flash_o.oe_n  <= reg_wr_i.data[1];
          flash_o.we_n  <= reg_wr_i.data[2];
          flash_o.adv_n <= reg_wr_i.data[3];
        end
        if (reg_wr_i.strb[1]) flash_o.dq_oe <= reg_wr_i.data[8];
        if (reg_wr_i.strb[2]) flash_o.region_oe <= reg_wr_i.data[16];
      end
    end
  end

  always_comb begin
    rd_data_o = '0;
    case (reg_rd_i.addr)
      REG_FLASH_ADDR: rd_data_o[23:0] = {flash_o.region, flash_o.addr};
      REG_FLASH_DATA: rd_data_o[FLASH_DQ_W-1:0] = flash_dq_i; // Pin state, not dq out
      REG_FLASH_CTRL: begin
        rd_data_o[3:0] = {flash_o.adv_n, flash_o.we_n, flash_o.oe_n, flash_o.ce_n};
        rd_data_o[8]   = flash_o.dq_oe;
        rd_data_o[16]  = flash_o.region_oe;
      end
      default: rd_data_o = '0; // Includes REG_FLASH_ID
    endcase
  end

endmodule

// File: hw/gpio_i2c_regs.sv
module gpio_i2c_regs
  import pcie_config_pkg::*;
(
  input  logic                   pcie_clk,
  input  logic                   pcie_rst,
  input  reg_wr_t                reg_wr_i,
  input  reg_rd_t                reg_rd_i,
  input  i2c_pins_t              i2c_i,
  output i2c_pins_t              i2c_o,
  output logic [AXIL_DATA_W-1:0] rd_data_o
);

  // SFP lines at bits 16-18, EEPROM lines at 24-25
  function automatic logic [AXIL_DATA_W-1:0] pin_word(input i2c_pins_t p);
    logic [AXIL_DATA_W-1:0] w;
    w     = '0;
    w[16] = p.sfp_scl;
    w[17] = p.sfp1_sda;
    w[18] = p.sfp2_sda;
    w[24] = p.eeprom_scl;
    w[25] = p.eeprom_sda;
    return w;
  endfunction

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      i2c_o <= '1; // Lines released
    end else if (reg_wr_i.valid && reg_wr_i.addr == REG_GPIO_OUT) begin
      if (reg_wr_i.strb[2]) begin
        i2c_o.sfp_scl  <= reg_wr_i.data[16];
        i2c_o.sfp1_sda <= reg_wr_i.data[17];
        i2c_o.sfp2_sda <= reg_wr_i.data[18];
      end
      if (reg_wr_i.strb[3]) begin
        i2c_o.eeprom_scl <= reg_wr_i.data[24];
        i2c_o.eeprom_sda <= reg_wr_i.data[25];
      end
    end
  end

  always_comb begin
    case (reg_rd_i.addr)
      REG_GPIO_OUT: rd_data_o = pin_word(i2c_o);
      REG_GPIO_IN:  rd_data_o = pin_word(i2c_i);
      default:      rd_data_o = '0;
    endcase
  end

endmodule

// File: hw/host_dma_channel.sv
module host_dma_channel
  import pcie_config_pkg::*;
#(
  parameter logic [REG_ADDR_W-1:0] BASE_ADDR = REG_DMA_RD_BASE
) (
  input  logic                   pcie_clk,
  input  logic                   pcie_rst,
  input  reg_wr_t                reg_wr_i,
  input  reg_rd_t                reg_rd_i,
  output dma_desc_t              desc_o,
  output logic                   desc_valid_o,
  input  logic                   desc_ready_i,
  input  logic [DMA_TAG_W-1:0]   status_tag_i,
  input  logic                   status_valid_i,
  output logic [AXIL_DATA_W-1:0] rd_data_o
);

  localparam logic [REG_ADDR_W-1:0] PCIE_LO_ADDR = BASE_ADDR + DMA_PCIE_LO;
  localparam logic [REG_ADDR_W-1:0] PCIE_HI_ADDR = BASE_ADDR + DMA_PCIE_HI;
  localparam logic [REG_ADDR_W-1:0] RAM_ADDR     = BASE_ADDR + DMA_RAM;
  localparam logic [REG_ADDR_W-1:0] LEN_ADDR     = BASE_ADDR + DMA_LEN;
  localparam logic [REG_ADDR_W-1:0] TAG_ADDR     = BASE_ADDR + DMA_TAG;
  localparam logic [REG_ADDR_W-1:0] STATUS_ADDR  = BASE_ADDR + DMA_STATUS;

  logic                 tag_wr;
  logic                 status_rd;
  logic [DMA_TAG_W-1:0] status_acc;

  assign tag_wr    = reg_wr_i.valid && reg_wr_i.addr == TAG_ADDR;
  assign status_rd = reg_rd_i.valid && reg_rd_i.addr == STATUS_ADDR;

  always_ff @(posedge pcie_clk) begin
    if (reg_wr_i.valid) begin
      case (reg_wr_i.addr)
        PCIE_LO_ADDR: desc_o.pcie_addr[31:0] <= reg_wr_i.data;
        PCIE_HI_ADDR: desc_o.pcie_addr[63:32] <= reg_wr_i.data;
        RAM_ADDR:     desc_o.ram_addr <= reg_wr_i.data[RAM_ADDR_W-1:0];
        LEN_ADDR:     desc_o.len <= reg_wr_i.data[DMA_LEN_W-1:0];
        TAG_ADDR:     desc_o.tag <= reg_wr_i.data[DMA_TAG_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_valid_o <= 1'b0;
      status_acc   <= '0;
    end else begin
      // A new tag wins over a same-cycle ready
      if (tag_wr) desc_valid_o <= 1'b1;
      else if (desc_ready_i) desc_valid_o <= 1'b0;

      // Clear on read, keeping a tag that arrives in the same cycle
      if (status_rd) status_acc <= status_valid_i ? status_tag_i : '0;
      else if (status_valid_i) status_acc <= status_acc | status_tag_i;
    end
  end

  always_comb begin
    rd_data_o = '0;
    case (reg_rd_i.addr)
      PCIE_LO_ADDR: rd_data_o = desc_o.pcie_addr[31:0];
      PCIE_HI_ADDR: rd_data_o = desc_o.pcie_addr[63:32];
      RAM_ADDR:     rd_data_o[RAM_ADDR_W-1:0] = desc_o.ram_addr;
      LEN_ADDR:     rd_data_o[DMA_LEN_W-1:0] = desc_o.len;
      TAG_ADDR:     rd_data_o[DMA_TAG_W-1:0] = desc_o.tag;
      STATUS_ADDR:  rd_data_o[DMA_TAG_W-1:0] = status_acc;
      default:      rd_data_o = '0;
    endcase
  end

endmodule

// File: hw/host_dma_regs.sv
module host_dma_regs
  import pcie_config_pkg::*;
(
  input  logic                   pcie_clk,
  input  logic                   pcie_rst,
  input  reg_wr_t                reg_wr_i,
  input  reg_rd_t                reg_rd_i,
  output logic                   dma_enable_o,
  output logic [AXIL_DATA_W-1:0] rd_data_o,

  output dma_desc_t              rd_desc_o,
  output logic                   rd_desc_valid_o,
  input  logic                   rd_desc_ready_i,
  input  logic [DMA_TAG_W-1:0]   rd_status_tag_i,
  input  logic                   rd_status_valid_i,

  output dma_desc_t              wr_desc_o,
  output logic                   wr_desc_valid_o,
  input  logic                   wr_desc_ready_i,
  input  logic [DMA_TAG_W-1:0]   wr_status_tag_i,
  input  logic                   wr_status_valid_i
);

  logic [AXIL_DATA_W-1:0] rd_ch_data;
  logic [AXIL_DATA_W-1:0] wr_ch_data;
  logic [AXIL_DATA_W-1:0] enable_data;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      dma_enable_o <= 1'b0;
    end else if (reg_wr_i.valid && reg_wr_i.addr == REG_DMA_ENABLE) begin
      dma_enable_o <= reg_wr_i.data[0];
    end
  end

  assign enable_data = {{(AXIL_DATA_W-1){1'b0}},
                        dma_enable_o && reg_rd_i.addr == REG_DMA_ENABLE};
  assign rd_data_o = enable_data | rd_ch_data | wr_ch_data;

  host_dma_channel #(.BASE_ADDR(REG_DMA_RD_BASE)) rd_channel (
    .pcie_clk      (pcie_clk),
    .pcie_rst      (pcie_rst),
    .reg_wr_i      (reg_wr_i),
    .reg_rd_i      (reg_rd_i),
    .desc_o        (rd_desc_o),
    .desc_valid_o  (rd_desc_valid_o),
    .desc_ready_i  (rd_desc_ready_i),
    .status_tag_i  (rd_status_tag_i),
    .status_valid_i(rd_status_valid_i),
    .rd_data_o     (rd_ch_data)
  );

  host_dma_channel #(.BASE_ADDR(REG_DMA_WR_BASE)) wr_channel (
    .pcie_clk      (pcie_clk),
    .pcie_rst      (pcie_rst),
    .reg_wr_i      (reg_wr_i),
    .reg_rd_i      (reg_rd_i),
    .desc_o        (wr_desc_o),
    .desc_valid_o  (wr_desc_valid_o),
    .desc_ready_i  (wr_desc_ready_i), // Own ready, not the read channel's
    .status_tag_i  (wr_status_tag_i),
    .status_valid_i(wr_status_valid_i),
    .rd_data_o     (wr_ch_data)
  );

endmodule

// File: hw/pcie_config_pkg.sv
package pcie_config_pkg;

  localparam int REG_ADDR_W  = 16;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // Identification words
  localparam logic [31:0] FW_ID          = 32'h0000_0000;
  localparam logic [31:0] FW_VER         = 32'h0000_0001;
  localparam logic [31:0] BOARD_ID       = 32'h1ce4_0003;
  localparam logic [31:0] BOARD_VER      = 32'h0000_0001;
  localparam logic [31:0] PHC_OFFSET     = 32'h0000_0200;
  localparam logic [31:0] PHC_STRIDE     = 32'h0000_0080;
  localparam logic [31:0] IF_COUNT       = 32'd2;
  localparam logic [31:0] IF_STRIDE      = 32'h8000_0000; // 2**31
  localparam logic [31:0] IF_CTRL_OFFSET = 32'h0400_0000; // 2**26

  localparam int PCIE_ADDR_W  = 64;
  localparam int RAM_ADDR_W   = 32;
  localparam int DMA_LEN_W    = 16;
  localparam int DMA_TAG_W    = 32;
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DQ_W   = 16;

  localparam logic [REG_ADDR_W-1:0] REG_FW_ID          = 16'h0000;
  localparam logic [REG_ADDR_W-1:0] REG_FW_VER         = 16'h0004;
  localparam logic [REG_ADDR_W-1:0] REG_BOARD_ID       = 16'h0008;
  localparam logic [REG_ADDR_W-1:0] REG_BOARD_VER      = 16'h000C;
  localparam logic [REG_ADDR_W-1:0] REG_PHC_COUNT      = 16'h0010;
  localparam logic [REG_ADDR_W-1:0] REG_PHC_OFFSET     = 16'h0014;
  localparam logic [REG_ADDR_W-1:0] REG_PHC_STRIDE     = 16'h0018;
  localparam logic [REG_ADDR_W-1:0] REG_IF_COUNT       = 16'h0020;
  localparam logic [REG_ADDR_W-1:0] REG_IF_STRIDE      = 16'h0024;
  localparam logic [REG_ADDR_W-1:0] REG_IF_CTRL_OFFSET = 16'h002C;

  localparam logic [REG_ADDR_W-1:0] REG_GPIO_OUT   = 16'h0100;
  localparam logic [REG_ADDR_W-1:0] REG_GPIO_IN    = 16'h0104;
  localparam logic [REG_ADDR_W-1:0] REG_FLASH_ID   = 16'h0140;
  localparam logic [REG_ADDR_W-1:0] REG_FLASH_ADDR = 16'h0144;
  localparam logic [REG_ADDR_W-1:0] REG_FLASH_DATA = 16'h0148;
  localparam logic [REG_ADDR_W-1:0] REG_FLASH_CTRL = 16'h014C;
  localparam logic [REG_ADDR_W-1:0] REG_DMA_ENABLE = 16'h0400;
  localparam logic [REG_ADDR_W-1:0] REG_DMA_RD_BASE = 16'h0440;
  localparam logic [REG_ADDR_W-1:0] REG_DMA_WR_BASE = 16'h0460;

  // Offsets inside a descriptor channel
  localparam logic [REG_ADDR_W-1:0] DMA_PCIE_LO = 16'h0000;
  localparam logic [REG_ADDR_W-1:0] DMA_PCIE_HI = 16'h0004;
  localparam logic [REG_ADDR_W-1:0] DMA_RAM     = 16'h0008;
  localparam logic [REG_ADDR_W-1:0] DMA_LEN     = 16'h0010;
  localparam logic [REG_ADDR_W-1:0] DMA_TAG     = 16'h0014;
  localparam logic [REG_ADDR_W-1:0] DMA_STATUS  = 16'h0018;

  typedef struct packed {
    logic                   valid;
    logic [REG_ADDR_W-1:0]  addr;
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
  } reg_wr_t;

  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] addr;
  } reg_rd_t;

  typedef struct packed {
    logic sfp_scl;
    logic sfp1_sda;
    logic sfp2_sda;
    logic eeprom_scl;
    logic eeprom_sda;
  } i2c_pins_t;

  typedef struct packed {
    logic [FLASH_DQ_W-1:0]   dq;
    logic                    dq_oe;
    logic [FLASH_ADDR_W-1:0] addr;
    logic                    region;
    logic                    region_oe;
    logic                    ce_n;
    logic                    oe_n;
    logic                    we_n;
    logic                    adv_n;
  } flash_out_t;

  typedef struct packed {
    logic [PCIE_ADDR_W-1:0] pcie_addr;
    logic [RAM_ADDR_W-1:0]  ram_addr;
    logic [DMA_LEN_W-1:0]   len;
    logic [DMA_TAG_W-1:0]   tag;
  } dma_desc_t;

endpackage

// File: hw/pcie_config_top.sv
module pcie_config_top
  import pcie_config_pkg::*;
(
  input  logic                   pcie_clk,
  input  logic                   pcie_rst,

  input  logic [31:0]            awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic [AXIL_DATA_W-1:0] wdata_i,
  input  logic [AXIL_STRB_W-1:0] wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output logic [1:0]             bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  input  logic [31:0]            araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [AXIL_DATA_W-1:0] rdata_o,
  output logic [1:0]             rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,

  input  i2c_pins_t              i2c_i,
  output i2c_pins_t              i2c_o,
  output i2c_pins_t              i2c_t_o,

  input  logic [FLASH_DQ_W-1:0]  flash_dq_i,
  output flash_out_t             flash_o,

  output logic                   dma_enable_o,

  output dma_desc_t              rd_desc_o,
  output logic                   rd_desc_valid_o,
  input  logic                   rd_desc_ready_i,
  input  logic [DMA_TAG_W-1:0]   rd_status_tag_i,
  input  logic                   rd_status_valid_i,

  output dma_desc_t              wr_desc_o,
  output logic                   wr_desc_valid_o,
  input  logic                   wr_desc_ready_i,
  input  logic [DMA_TAG_W-1:0]   wr_status_tag_i,
  input  logic                   wr_status_valid_i
);

  reg_wr_t                reg_wr;
  reg_rd_t                reg_rd;
  logic [AXIL_DATA_W-1:0] gpio_rd_data;
  logic [AXIL_DATA_W-1:0] flash_rd_data;
  logic [AXIL_DATA_W-1:0] dma_rd_data;

  assign i2c_t_o = i2c_o; // Open drain, driving 1 releases the line

  axil_reg_if axil_reg_if_inst (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .awaddr_i       (awaddr_i),
    .awvalid_i      (awvalid_i),
    .awready_o      (awready_o),
    .wdata_i        (wdata_i),
    .wstrb_i        (wstrb_i),
    .wvalid_i       (wvalid_i),
    .wready_o       (wready_o),
    .bresp_o        (bresp_o),
    .bvalid_o       (bvalid_o),
    .bready_i       (bready_i),
    .araddr_i       (araddr_i),
    .arvalid_i      (arvalid_i),
    .arready_o      (arready_o),
    .rdata_o        (rdata_o),
    .rresp_o        (rresp_o),
    .rvalid_o       (rvalid_o),
    .rready_i       (rready_i),
    .reg_wr_o       (reg_wr),
    .reg_rd_o       (reg_rd),
    .gpio_rd_data_i (gpio_rd_data),
    .flash_rd_data_i(flash_rd_data),
    .dma_rd_data_i  (dma_rd_data)
  );

  gpio_i2c_regs gpio_i2c_regs_inst (
    .pcie_clk (pcie_clk),
    .pcie_rst (pcie_rst),
    .reg_wr_i (reg_wr),
    .reg_rd_i (reg_rd),
    .i2c_i    (i2c_i),
    .i2c_o    (i2c_o),
    .rd_data_o(gpio_rd_data)
  );

  bpi_flash_regs bpi_flash_regs_inst (
    .pcie_clk  (pcie_clk),
    .pcie_rst  (pcie_rst),
    .reg_wr_i  (reg_wr),
    .reg_rd_i  (reg_rd),
    .flash_dq_i(flash_dq_i),
    .flash_o   (flash_o),
    .rd_data_o (flash_rd_data)
  );

  host_dma_regs host_dma_regs_inst (
    .pcie_clk         (pcie_clk),
    .pcie_rst         (pcie_rst),
    .reg_wr_i         (reg_wr),
    .reg_rd_i         (reg_rd),
    .dma_enable_o     (dma_enable_o),
    .rd_data_o        (dma_rd_data),
    .rd_desc_o        (rd_desc_o),
    .rd_desc_valid_o  (rd_desc_valid_o),
    .rd_desc_ready_i  (rd_desc_ready_i),
    .rd_status_tag_i  (rd_status_tag_i),
    .rd_status_valid_i(rd_status_valid_i),
    .wr_desc_o        (wr_desc_o),
    .wr_desc_valid_o  (wr_desc_valid_o),
    .wr_desc_ready_i  (wr_desc_ready_i),
    .wr_status_tag_i  (wr_status_tag_i),
    .wr_status_valid_i(wr_status_valid_i)
  );

endmodule

// File: test/pcie_config_checker.sv
module pcie_config_checker
  import pcie_config_pkg::*;
(
  input logic      pcie_clk,
  input logic      pcie_rst,
  input logic      awready_o,
  input logic      arready_o,
  input logic      bvalid_o,
  input logic      bready_i,
  input logic      rvalid_o,
  input logic      rready_i,
  input logic [1:0] bresp_o,
  input logic [1:0] rresp_o,
  input dma_desc_t rd_desc_o,
  input logic      rd_desc_valid_o,
  input logic      rd_desc_ready_i,
  input dma_desc_t wr_desc_o,
  input logic      wr_desc_valid_o,
  input logic      wr_desc_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  bvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_o && !bready_i |=> bvalid_o)
    else $error("write response valid dropped before ready");

  rvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rvalid_o && !rready_i |=> rvalid_o)
    else $error("read response valid dropped before ready");

  awready_pulse: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    awready_o |=> !awready_o)
    else $error("write address ready high two cycles running");

  arready_pulse: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    arready_o |=> !arready_o)
    else $error("read address ready high two cycles running");

  rd_desc_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rd_desc_valid_o && !rd_desc_ready_i |=> rd_desc_valid_o && $stable(rd_desc_o))
    else $error("read descriptor changed or dropped before ready");

  wr_desc_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    wr_desc_valid_o && !wr_desc_ready_i |=> wr_desc_valid_o && $stable(wr_desc_o))
    else $error("write descriptor changed or dropped before ready");

  resp_okay: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bresp_o == 2'b00 && rresp_o == 2'b00)
    else $error("nonzero response code");

endmodule

bind pcie_config_top pcie_config_checker pcie_config_checker_inst (.*);

// File: test/pcie_config_tb.sv
module pcie_config_tb
  import pcie_config_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 40;
  localparam logic [1:0] OP_WR = 2'd0;
  localparam logic [1:0] OP_RD = 2'd1;
  localparam logic [1:0] OP_PIN = 2'd2; // addr selects the pin group

  typedef struct packed {
    logic [1:0]  op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp;
    logic [31:0] mask;
  } step_t;

  logic pcie_clk, pcie_rst;
  logic [31:0] awaddr_i, wdata_i, araddr_i, rdata_o;
  logic [3:0] wstrb_i;
  logic awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
  logic arvalid_i, arready_o, rvalid_o, rready_i;
  logic [1:0] bresp_o, rresp_o;
  i2c_pins_t i2c_i, i2c_o, i2c_t_o;
  logic [FLASH_DQ_W-1:0] flash_dq_i;
  flash_out_t flash_o;
  logic dma_enable_o;
  dma_desc_t rd_desc_o, wr_desc_o;
  logic rd_desc_valid_o, rd_desc_ready_i, rd_status_valid_i;
  logic wr_desc_valid_o, wr_desc_ready_i, wr_status_valid_i;
  logic [DMA_TAG_W-1:0] rd_status_tag_i, wr_status_tag_i;

  int errors = 0;
  int seed = 32'ha0b1_1ee7;
  bit hung = 1'b0;
  bit auto_ready = 1'b0;

  step_t steps [$] = '{
    '{OP_PIN, 16'd0, 32'h0, 4'h0, 32'h0000_03ff, 32'hffff_ffff}, // Released I2C
    '{OP_PIN, 16'd1, 32'h0, 4'h0, 32'h0000_000f, 32'hffff_ffff},
    '{OP_PIN, 16'd2, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_PIN, 16'd3, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_PIN, 16'd4, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_PIN, 16'd5, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_RD, 16'h0000, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_RD, 16'h0004, 32'h0, 4'h0, 32'h0000_0001, 32'hffff_ffff},
    '{OP_RD, 16'h0008, 32'h0, 4'h0, 32'h1ce4_0003, 32'hffff_ffff},
    '{OP_RD, 16'h000c, 32'h0, 4'h0, 32'h0000_0001, 32'hffff_ffff},
    '{OP_RD, 16'h0010, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_RD, 16'h0014, 32'h0, 4'h0, 32'h0000_0200, 32'hffff_ffff},
    '{OP_RD, 16'h0018, 32'h0, 4'h0, 32'h0000_0080, 32'hffff_ffff},
    '{OP_RD, 16'h0020, 32'h0, 4'h0, 32'h0000_0002, 32'hffff_ffff},
    '{OP_RD, 16'h0024, 32'h0, 4'h0, 32'h8000_0000, 32'hffff_ffff},
    '{OP_RD, 16'h002c, 32'h0, 4'h0, 32'h0400_0000, 32'hffff_ffff},
    '{OP_RD, 16'h001c, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff}, // Unmapped
    '{OP_RD, 16'h0300, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_WR, 16'h0100, 32'h0000_0000, 4'b0100, 32'h0, 32'h0},
    '{OP_PIN, 16'd0, 32'h0, 4'h0, 32'h0000_0063, 32'hffff_ffff},
    '{OP_RD, 16'h0100, 32'h0, 4'h0, 32'h0300_0000, 32'hffff_ffff},
    '{OP_WR, 16'h0100, 32'h0105_0000, 4'b1000, 32'h0, 32'h0},
    '{OP_PIN, 16'd0, 32'h0, 4'h0, 32'h0000_0042, 32'hffff_ffff},
    '{OP_RD, 16'h0100, 32'h0, 4'h0, 32'h0100_0000, 32'hffff_ffff},
    '{OP_WR, 16'h0100, 32'h0005_0000, 4'b0011, 32'h0, 32'h0}, // No line strobes
    '{OP_RD, 16'h0100, 32'h0, 4'h0, 32'h0100_0000, 32'hffff_ffff},
    '{OP_WR, 16'h0100, 32'h0206_0000, 4'b1100, 32'h0, 32'h0},
    '{OP_PIN, 16'd0, 32'h0, 4'h0, 32'h0000_01ad, 32'hffff_ffff},
    '{OP_RD, 16'h0100, 32'h0, 4'h0, 32'h0206_0000, 32'hffff_ffff},
    '{OP_WR, 16'h0144, 32'h0123_4567, 4'b0001, 32'h0, 32'h0},
    '{OP_PIN, 16'd2, 32'h0, 4'h0, 32'h0000_0067, 32'hffff_ffff},
    '{OP_WR, 16'h0144, 32'h00ab_cdef, 4'b0110, 32'h0, 32'h0},
    '{OP_PIN, 16'd2, 32'h0, 4'h0, 32'h00ab_cd67, 32'hffff_ffff},
    '{OP_RD, 16'h0144, 32'h0, 4'h0, 32'h00ab_cd67, 32'hffff_ffff},
    '{OP_WR, 16'h0148, 32'h1234_5678, 4'b0010, 32'h0, 32'h0},
    '{OP_PIN, 16'd3, 32'h0, 4'h0, 32'h0000_5600, 32'hffff_ffff},
    '{OP_WR, 16'h0148, 32'h1234_5678, 4'b0001, 32'h0, 32'h0},
    '{OP_PIN, 16'd3, 32'h0, 4'h0, 32'h0000_5678, 32'hffff_ffff},
    '{OP_WR, 16'h014c, 32'h0001_0105, 4'b0001, 32'h0, 32'h0},
    '{OP_PIN, 16'd1, 32'h0, 4'h0, 32'h0000_0005, 32'hffff_ffff},
    '{OP_RD, 16'h014c, 32'h0, 4'h0, 32'h0000_0005, 32'hffff_ffff},
    '{OP_WR, 16'h014c, 32'h0001_0105, 4'b0110, 32'h0, 32'h0},
    '{OP_PIN, 16'd1, 32'h0, 4'h0, 32'h0000_0035, 32'hffff_ffff},
    '{OP_RD, 16'h014c, 32'h0, 4'h0, 32'h0001_0105, 32'hffff_ffff},
    '{OP_RD, 16'h0140, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_WR, 16'h0400, 32'hffff_ffff, 4'b1111, 32'h0, 32'h0},
    '{OP_PIN, 16'd4, 32'h0, 4'h0, 32'h0000_0001, 32'hffff_ffff},
    '{OP_RD, 16'h0400, 32'h0, 4'h0, 32'h0000_0001, 32'hffff_ffff},
    '{OP_WR, 16'h0400, 32'hffff_fffe, 4'b1111, 32'h0, 32'h0},
    '{OP_PIN, 16'd4, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff},
    '{OP_RD, 16'h0400, 32'h0, 4'h0, 32'h0000_0000, 32'hffff_ffff}
  };

  pcie_config_top pcie_config_top_inst (.*);

  initial begin
    pcie_clk = 1'b0;
    forever #4 pcie_clk = ~pcie_clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Never returns; the watchdog process ends the run
  task automatic report_hang(input string what);
    $display("ERROR: timed out waiting for %s", what);
    hung = 1'b1;
    forever @(posedge pcie_clk);
  endtask

  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int t;
    t = 0;
    @(posedge pcie_clk);
    awaddr_i  <= {16'h0, addr};
    wdata_i   <= data;
    wstrb_i   <= strb;
    awvalid_i <= 1'b1;
    wvalid_i  <= 1'b1;
    bready_i  <= 1'b0;
    do begin
      @(negedge pcie_clk);
      t++;
    end while (!bvalid_o && t < TIMEOUT);
    if (!bvalid_o) report_hang("write response");
    // Response waits a cycle before it is taken
    @(posedge pcie_clk);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    bready_i  <= 1'b1;
    @(posedge pcie_clk);
    bready_i  <= 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
    int t;
    t = 0;
    @(posedge pcie_clk);
    araddr_i  <= {16'h0, addr};
    arvalid_i <= 1'b1;
    rready_i  <= 1'b0;
    do begin
      @(negedge pcie_clk);
      t++;
    end while (!rvalid_o && t < TIMEOUT);
    if (!rvalid_o) report_hang("read response");
    data = rdata_o;
    @(posedge pcie_clk);
    arvalid_i <= 1'b0;
    rready_i  <= 1'b1;
    @(posedge pcie_clk);
    rready_i  <= 1'b0;
  endtask

  function automatic logic [31:0] pin_value(input logic [15:0] sel);
    case (sel)
      16'd0:   return {22'h0, i2c_t_o, i2c_o};
      16'd1:   return {26'h0, flash_o.region_oe, flash_o.dq_oe, flash_o.adv_n,
                       flash_o.we_n, flash_o.oe_n, flash_o.ce_n};
      16'd2:   return {8'h0, flash_o.region, flash_o.addr};
      16'd3:   return {16'h0, flash_o.dq};
      16'd4:   return {31'h0, dma_enable_o};
      default: return {25'h0, rd_desc_valid_o, wr_desc_valid_o, awready_o, wready_o,
                       arready_o, bvalid_o, rvalid_o};
    endcase
  endfunction

  // Pulses ready after 0-7 cycles once valid is seen
  task automatic respond(input bit is_wr);
    int delay;
    forever begin
      @(negedge pcie_clk);
      if (auto_ready && (is_wr ? wr_desc_valid_o : rd_desc_valid_o)) begin
        delay = $random(seed) & 7;
        repeat (delay) @(posedge pcie_clk);
        @(posedge pcie_clk);
        if (is_wr) wr_desc_ready_i <= 1'b1;
        else rd_desc_ready_i <= 1'b1;
        @(posedge pcie_clk);
        if (is_wr) wr_desc_ready_i <= 1'b0;
        else rd_desc_ready_i <= 1'b0;
      end
    end
  endtask

  task automatic run_channel(input bit is_wr);
    logic [15:0] base;
    logic [63:0] pa;
    logic [31:0] ra, len, tag;
    dma_desc_t d;
    int t;
    base = is_wr ? 16'h0460 : 16'h0440;
    pa   = {$random(seed), $random(seed)};
    ra   = $random(seed);
    len  = $random(seed);
    tag  = $random(seed);
    axil_write(base, pa[31:0], 4'hf);
    axil_write(base + 16'h4, pa[63:32], 4'hf);
    axil_write(base + 16'h8, ra, 4'hf);
    axil_write(base + 16'h10, len, 4'hf);
    axil_write(base + 16'h14, tag, 4'hf);
    @(negedge pcie_clk);
    d = is_wr ? wr_desc_o : rd_desc_o;
    check_value("desc_valid", {31'h0, is_wr ? wr_desc_valid_o : rd_desc_valid_o}, 32'h1);
    check_value("desc.pcie_addr_lo", d.pcie_addr[31:0], pa[31:0]);
    check_value("desc.pcie_addr_hi", d.pcie_addr[63:32], pa[63:32]);
    check_value("desc.ram_addr", d.ram_addr, ra);
    check_value("desc.len", {16'h0, d.len}, {16'h0, len[15:0]});
    check_value("desc.tag", d.tag, tag);
    // Other channel's ready must leave this one alone
    @(posedge pcie_clk);
    if (is_wr) rd_desc_ready_i <= 1'b1;
    else wr_desc_ready_i <= 1'b1;
    @(posedge pcie_clk);
    rd_desc_ready_i <= 1'b0;
    wr_desc_ready_i <= 1'b0;
    @(negedge pcie_clk);
    check_value("desc_valid", {31'h0, is_wr ? wr_desc_valid_o : rd_desc_valid_o}, 32'h1);
    auto_ready = 1'b1;
    t = 0;
    while ((is_wr ? wr_desc_valid_o : rd_desc_valid_o) && t < TIMEOUT) begin
      @(negedge pcie_clk);
      t++;
    end
    if (is_wr ? wr_desc_valid_o : rd_desc_valid_o) report_hang("descriptor ready");
    auto_ready = 1'b0;
  endtask

  task automatic run_status(input bit is_wr);
    logic [31:0] acc, tag, got;
    acc = '0;
    repeat (4) begin
      tag = $random(seed);
      acc = acc | tag;
      @(posedge pcie_clk);
      if (is_wr) {wr_status_valid_i, wr_status_tag_i} <= {1'b1, tag};
      else {rd_status_valid_i, rd_status_tag_i} <= {1'b1, tag};
    end
    @(posedge pcie_clk);
    wr_status_valid_i <= 1'b0;
    rd_status_valid_i <= 1'b0;
    axil_read(is_wr ? 16'h0478 : 16'h0458, got);
    check_value("status_acc", got, acc);
    axil_read(is_wr ? 16'h0478 : 16'h0458, got);
    check_value("status_acc after clear", got, 32'h0);
  endtask

  initial begin
    wait (hung);
    $display("Run aborted with %0d value errors and a timeout", errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    fork
      respond(1'b0);
      respond(1'b1);
    join_none
  end

  initial begin
    logic [31:0] got;
    logic [4:0] pins;
    pcie_rst <= 1'b1;
    {awaddr_i, wdata_i, wstrb_i, awvalid_i, wvalid_i, bready_i} <= '0;
    {araddr_i, arvalid_i, rready_i} <= '0;
    i2c_i <= '1;
    flash_dq_i <= '0;
    {rd_desc_ready_i, rd_status_tag_i, rd_status_valid_i} <= '0;
    {wr_desc_ready_i, wr_status_tag_i, wr_status_valid_i} <= '0;
    repeat (16) @(posedge pcie_clk);
    pcie_rst <= 1'b0;

    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WR: axil_write(steps[i].addr, steps[i].data, steps[i].strb);
        OP_RD: begin
          axil_read(steps[i].addr, got);
          check_value($sformatf("rdata@%h", steps[i].addr), got & steps[i].mask,
                      steps[i].exp & steps[i].mask);
        end
        default: begin
          @(negedge pcie_clk);
          check_value($sformatf("pin group %0d", steps[i].addr),
                      pin_value(steps[i].addr) & steps[i].mask, steps[i].exp & steps[i].mask);
        end
      endcase
    end

    pins = 5'($random(seed));
    @(posedge pcie_clk);
    i2c_i <= pins;
    flash_dq_i <= 16'($random(seed));
    axil_read(16'h0104, got);
    check_value("gpio_in", got, {6'h0, pins[0], pins[1], 5'h0, pins[2], pins[3], pins[4], 16'h0});
    axil_read(16'h0148, got);
    check_value("flash_dq_in", got, {16'h0, flash_dq_i});

    run_channel(1'b0);
    run_channel(1'b1);
    run_status(1'b0);
    run_status(1'b1);

    $display("Run finished with %0d errors", errors);
    if (errors == 0) $display("*** TEST PASSED ***");
    else $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
